// File: rtl/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and register width
`define CPU_XLEN 16

// architectural registers r0..r15
`define CPU_NREGS 16

// instruction memory size in 16-bit words
`define CPU_IMEM_DEPTH 256

// data memory size in 16-bit words
// both memories index with byte address bits above bit 0
`define CPU_DMEM_DEPTH 256

`endif

// File: rtl/cpu_pkg.sv
package cpu_pkg;

	// major opcode in instr[15:12]
	// codes 3, 7 and D are unused and fall through as no-ops
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_SLL = 4'h4,
		OP_SRA = 4'h5,
		OP_ROR = 4'h6,
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LLB = 4'hA,
		OP_LHB = 4'hB,
		OP_B   = 4'hC,
		OP_PCS = 4'hE,
		OP_HLT = 4'hF
	} opcode_e;

	// operation performed by the ALU
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_SLL,
		ALU_SRA,
		ALU_ROR,
		// source 1 goes straight through
		ALU_PASS
	} alu_op_e;

	// source of the register write-back value
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC2,
		WB_BYTE
	} wb_src_e;

	// condition flags
	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

endpackage

// File: rtl/cpu_if.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

// fetch block <-> execute block
interface fetch_if;
	logic [`CPU_XLEN-1:0] instr;
	logic [`CPU_XLEN-1:0] pc;
	// branch condition holds for the current B
	logic taken;
	// current instruction is HLT
	logic halt;

	modport fetch (
		output instr,
		output pc,
		input taken,
		input halt
	);

	modport exec (
		input instr,
		input pc,
		output taken,
		output halt
	);
endinterface

// execute block <-> memory and write-back block
interface wb_if;
	logic [`CPU_XLEN-1:0] alu_result;
	// rd value of a SW
	logic [`CPU_XLEN-1:0] store_data;
	logic mem_read;
	logic mem_write;
	cpu_pkg::wb_src_e wb_src;
	logic reg_write;
	logic [$clog2(`CPU_NREGS)-1:0] dst;
	logic [7:0] imm8;
	// high byte merge for LHB, low byte for LLB
	logic byte_hi;
	logic [`CPU_XLEN-1:0] pc_plus2;
	logic [`CPU_XLEN-1:0] wb_data;

	modport exec (
		output alu_result,
		output store_data,
		output mem_read,
		output mem_write,
		output wb_src,
		output reg_write,
		output dst,
		output imm8,
		output byte_hi,
		output pc_plus2,
		input wb_data
	);

	modport wb (
		input alu_result,
		input store_data,
		input mem_read,
		input mem_write,
		input wb_src,
		input imm8,
		input byte_hi,
		input pc_plus2,
		output wb_data
	);
endinterface

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetch_unit (
	input logic clk,
	input logic reset,
	input logic load_en,
	input logic [$clog2(`CPU_IMEM_DEPTH)-1:0] load_addr,
	input logic [`CPU_XLEN-1:0] load_data,
	fetch_if.fetch fif
);
	import cpu_pkg::*;

	localparam int XLEN = `CPU_XLEN;
	localparam int IAW = $clog2(`CPU_IMEM_DEPTH);

	// program storage
	logic [XLEN-1:0] imem [`CPU_IMEM_DEPTH];

	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] pc_plus2;
	logic [XLEN-1:0] branch_off;
	logic [XLEN-1:0] pc_next;

	// program load only while the core is held in reset
	always_ff @(posedge clk) begin
		if (reset && load_en) begin
			imem[load_addr] <= load_data;
		end
	end

	// asynchronous read with the word index taken from the byte pc
	assign fif.instr = imem[pc_q[IAW:1]];
	assign fif.pc = pc_q;

	// 9-bit word offset becomes a byte offset
	assign branch_off = {{(XLEN-10){fif.instr[8]}}, fif.instr[8:0], 1'b0};
	assign pc_plus2 = pc_q + XLEN'(2);

	always_comb begin
		if (fif.halt) begin
			pc_next = pc_q;
		end else if (fif.taken) begin
			pc_next = pc_plus2 + branch_off;
		end else begin
			pc_next = pc_plus2;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q <= '0;
		end else begin
			pc_q <= pc_next;
		end
	end

	// instructions stay halfword aligned
	a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
		fif.pc[0] == 1'b0);

	// a halted core keeps its pc
	a_halt_hold: assert property (@(posedge clk) disable iff (reset)
		fif.halt |=> $stable(fif.pc));

endmodule

// File: rtl/core_execute.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module core_execute (
	input logic clk,
	input logic reset,
	fetch_if.exec fif,
	wb_if.exec wif
);
	import cpu_pkg::*;

	localparam int XLEN = `CPU_XLEN;
	localparam int RW = $clog2(`CPU_NREGS);

	logic [XLEN-1:0] regs [`CPU_NREGS];

	opcode_e op;
	alu_op_e alu_op;
	wb_src_e wb_src;
	flags_t flag_q;
	flags_t flag_new;
	logic [RW-1:0] rd;
	logic [RW-1:0] rs1;
	logic [RW-1:0] rs2;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [XLEN-1:0] src1;
	logic [XLEN-1:0] src2;
	logic [XLEN-1:0] alu_out;
	logic [2*XLEN-1:0] rot;
	logic [3:0] imm4;
	logic rs1_is_rd, rs2_is_rd;
	logic use_shamt, use_offset;
	logic reg_write, mem_read, mem_write;
	logic flag_we_all, flag_we_z;
	logic cond_true;

	assign op = opcode_e'(fif.instr[15:12]);
	assign rd = fif.instr[11:8];
	assign imm4 = fif.instr[3:0];

	// control decode
	always_comb begin
		alu_op = ALU_PASS;
		wb_src = WB_ALU;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		flag_we_all = 1'b0;
		flag_we_z = 1'b0;
		rs1_is_rd = 1'b0;
		rs2_is_rd = 1'b0;
		use_shamt = 1'b0;
		use_offset = 1'b0;
		case (op)
			OP_ADD, OP_SUB: begin
				alu_op = (op == OP_ADD) ? ALU_ADD : ALU_SUB;
				reg_write = 1'b1;
				flag_we_all = 1'b1;
			end
			OP_XOR: begin
				alu_op = ALU_XOR;
				reg_write = 1'b1;
				flag_we_z = 1'b1;
			end
			OP_SLL, OP_SRA, OP_ROR: begin
				alu_op = (op == OP_SLL) ? ALU_SLL : (op == OP_SRA) ? ALU_SRA : ALU_ROR;
				use_shamt = 1'b1;
				reg_write = 1'b1;
				flag_we_z = 1'b1;
			end
			OP_LW: begin
				alu_op = ALU_ADD;
				use_offset = 1'b1;
				mem_read = 1'b1;
				wb_src = WB_MEM;
				reg_write = 1'b1;
			end
			OP_SW: begin
				// store data is rd, read on port 2
				alu_op = ALU_ADD;
				use_offset = 1'b1;
				mem_write = 1'b1;
				rs2_is_rd = 1'b1;
			end
			OP_LLB, OP_LHB: begin
				// old rd value passes through for the byte merge
				rs1_is_rd = 1'b1;
				wb_src = WB_BYTE;
				reg_write = 1'b1;
			end
			OP_PCS: begin
				wb_src = WB_PC2;
				reg_write = 1'b1;
			end
			default: begin
				// B, HLT and unused codes write nothing
			end
		endcase
	end

	// register file, two async reads and one write per edge
	assign rs1 = rs1_is_rd ? rd : fif.instr[7:4];
	assign rs2 = rs2_is_rd ? rd : fif.instr[3:0];
	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CPU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wif.reg_write) begin
			regs[wif.dst] <= wif.wb_data;
		end
	end

	// memory base is forced to a word boundary
	assign src1 = use_offset ? {rs1_data[XLEN-1:1], 1'b0} : rs1_data;

	always_comb begin
		if (use_offset) begin
			src2 = {{(XLEN-5){imm4[3]}}, imm4, 1'b0};
		end else if (use_shamt) begin
			src2 = XLEN'(imm4);
		end else begin
			src2 = rs2_data;
		end
	end

	// rotate right through a doubled copy
	assign rot = {src1, src1} >> src2[3:0];

	always_comb begin
		case (alu_op)
			ALU_ADD: alu_out = src1 + src2;
			ALU_SUB: alu_out = src1 - src2;
			ALU_XOR: alu_out = src1 ^ src2;
			ALU_SLL: alu_out = src1 << src2[3:0];
			ALU_SRA: alu_out = $signed(src1) >>> src2[3:0];
			ALU_ROR: alu_out = rot[XLEN-1:0];
			default: alu_out = src1;
		endcase
	end

	// flag update, ADD/SUB set all three, logic and shifts only z
	always_comb begin
		flag_new = flag_q;
		if (flag_we_all || flag_we_z) begin
			flag_new.z = (alu_out == '0);
		end
		if (flag_we_all) begin
			flag_new.n = alu_out[XLEN-1];
			// signed overflow, operand signs compared per operation
			if (alu_op == ALU_SUB) begin
				flag_new.v = (src1[XLEN-1] != src2[XLEN-1]) && (alu_out[XLEN-1] != src1[XLEN-1]);
			end else begin
				flag_new.v = (src1[XLEN-1] == src2[XLEN-1]) && (alu_out[XLEN-1] != src1[XLEN-1]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			flag_q <= '0;
		end else begin
			flag_q <= flag_new;
		end
	end

	// branch condition against the stored flags
	always_comb begin
		case (fif.instr[11:9])
			3'b000: cond_true = ~flag_q.z;
			3'b001: cond_true = flag_q.z;
			3'b010: cond_true = ~flag_q.z & ~flag_q.n;
			3'b011: cond_true = flag_q.n;
			3'b100: cond_true = flag_q.z | ~flag_q.n;
			3'b101: cond_true = flag_q.n | flag_q.z;
			3'b110: cond_true = flag_q.v;
			default: cond_true = 1'b1;
		endcase
	end

	assign fif.taken = (op == OP_B) && cond_true;
	assign fif.halt = (op == OP_HLT);

	assign wif.alu_result = alu_out;
	assign wif.store_data = rs2_data;
	assign wif.mem_read = mem_read;
	assign wif.mem_write = mem_write;
	assign wif.wb_src = wb_src;
	assign wif.reg_write = reg_write;
	assign wif.dst = rd;
	assign wif.imm8 = fif.instr[7:0];
	assign wif.byte_hi = (op == OP_LHB);
	assign wif.pc_plus2 = fif.pc + XLEN'(2);

	// a single data memory port, never read and write together
	a_mem_excl: assert property (@(posedge clk) disable iff (reset)
		!(wif.mem_read && wif.mem_write));

endmodule

// File: rtl/mem_writeback.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module mem_writeback (
	input logic clk,
	wb_if.wb wif
);
	import cpu_pkg::*;

	localparam int XLEN = `CPU_XLEN;
	localparam int DAW = $clog2(`CPU_DMEM_DEPTH);

	// data storage, contents undefined until stored
	logic [XLEN-1:0] dmem [`CPU_DMEM_DEPTH];

	logic [DAW-1:0] daddr;
	logic [XLEN-1:0] load_data;
	logic [XLEN-1:0] byte_merge;

	// word index from the byte address, wraps at the depth
	assign daddr = wif.alu_result[DAW:1];

	always_ff @(posedge clk) begin
		if (wif.mem_write) begin
			dmem[daddr] <= wif.store_data;
		end
	end

	// asynchronous read, quiet unless a load is active
	assign load_data = wif.mem_read ? dmem[daddr] : '0;

	// LHB replaces the high byte, LLB the low byte of the old rd
	assign byte_merge = wif.byte_hi ? {wif.imm8, wif.alu_result[7:0]}
		: {wif.alu_result[XLEN-1:8], wif.imm8};

	always_comb begin
		case (wif.wb_src)
			WB_MEM: wif.wb_data = load_data;
			WB_PC2: wif.wb_data = wif.pc_plus2;
			WB_BYTE: wif.wb_data = byte_merge;
			default: wif.wb_data = wif.alu_result;
		endcase
	end

endmodule

// File: rtl/cpu.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu (
	input logic clk,
	input logic reset,
	// program load, honored only while reset is high
	input logic load_en,
	input logic [$clog2(`CPU_IMEM_DEPTH)-1:0] load_addr,
	input logic [`CPU_XLEN-1:0] load_data,
	output logic hlt,
	output logic [`CPU_XLEN-1:0] pc,
	// one entry per register write
	output logic commit_en,
	output logic [$clog2(`CPU_NREGS)-1:0] commit_reg,
	output logic [`CPU_XLEN-1:0] commit_data
);

	fetch_if fif ();
	wb_if wif ();

	// pc, instruction memory and next-pc
	fetch_unit fetch_unit_inst (
		.clk(clk),
		.reset(reset),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.fif(fif.fetch)
	);

	// decode, registers, ALU and flags
	core_execute core_execute_inst (
		.clk(clk),
		.reset(reset),
		.fif(fif.exec),
		.wif(wif.exec)
	);

	// data memory and write-back select
	mem_writeback mem_writeback_inst (
		.clk(clk),
		.wif(wif.wb)
	);

	assign hlt = fif.halt;
	assign pc = fif.pc;

	// no commits reported while the program is loading
	assign commit_en = wif.reg_write & ~reset;
	assign commit_reg = wif.dst;
	assign commit_data = wif.wb_data;

endmodule

// File: bench/cpu_model.svh
localparam int PROG_WORDS = 64;

// reference state, one instruction per call
logic [`CPU_XLEN-1:0] m_regs [`CPU_NREGS];
logic [`CPU_XLEN-1:0] m_dmem [`CPU_DMEM_DEPTH];
logic [`CPU_XLEN-1:0] m_pc;
logic m_z;
logic m_v;
logic m_n;
// current instruction is HLT
logic m_halt;
// register write made by the last instruction
logic m_wen;
logic [3:0] m_wreg;
logic [`CPU_XLEN-1:0] m_wdata;

logic [`CPU_XLEN-1:0] prog [PROG_WORDS];
// r1 offsets already stored along the executed path
int stored_off [$];

task automatic reset_model();
	m_pc = '0;
	m_z = 1'b0;
	m_v = 1'b0;
	m_n = 1'b0;
	m_halt = 1'b0;
	m_wen = 1'b0;
	m_wreg = '0;
	m_wdata = '0;
	for (int i = 0; i < `CPU_NREGS; i++) begin
		m_regs[i] = '0;
	end
	for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
		m_dmem[i] = 'x;
	end
endtask

// condition code table of B
function automatic logic branch_cond(input logic [2:0] cc);
	case (cc)
		3'd0: return !m_z;
		3'd1: return m_z;
		3'd2: return !m_z && !m_n;
		3'd3: return m_n;
		3'd4: return m_z || !m_n;
		3'd5: return m_z || m_n;
		3'd6: return m_v;
		default: return 1'b1;
	endcase
endfunction

task automatic execute_instr(input logic [`CPU_XLEN-1:0] ins);
	logic [3:0] rd;
	logic [3:0] sh;
	logic [`CPU_XLEN-1:0] a;
	logic [`CPU_XLEN-1:0] b;
	logic [`CPU_XLEN-1:0] r;
	logic [`CPU_XLEN-1:0] addr;
	logic [`CPU_XLEN-1:0] next_pc;
	rd = ins[11:8];
	sh = ins[3:0];
	a = m_regs[ins[7:4]];
	b = m_regs[ins[3:0]];
	// even base plus twice the signed offset
	addr = {a[15:1], 1'b0} + {{11{sh[3]}}, sh, 1'b0};
	r = '0;
	m_wen = 1'b0;
	m_wreg = rd;
	m_wdata = '0;
	m_halt = 1'b0;
	next_pc = m_pc + 16'd2;
	case (ins[15:12])
		4'h0, 4'h1: begin
			r = (ins[12] == 1'b0) ? a + b : a - b;
			// overflow when the result sign is wrong for the operand signs
			if (ins[12] == 1'b0) begin
				m_v = (a[15] == b[15]) && (r[15] != a[15]);
			end else begin
				m_v = (a[15] != b[15]) && (r[15] != a[15]);
			end
			m_n = r[15];
			m_z = (r == '0);
			m_wen = 1'b1;
			m_wdata = r;
		end
		4'h2, 4'h4, 4'h5, 4'h6: begin
			case (ins[15:12])
				4'h2: r = a ^ b;
				4'h4: r = a << sh;
				4'h5: r = $signed(a) >>> sh;
				default: r = (a >> sh) | (a << (5'd16 - {1'b0, sh}));
			endcase
			// only z follows logic and shift results
			m_z = (r == '0);
			m_wen = 1'b1;
			m_wdata = r;
		end
		4'h8: begin
			m_wen = 1'b1;
			m_wdata = m_dmem[addr[8:1]];
		end
		4'h9: m_dmem[addr[8:1]] = m_regs[rd];
		4'hA: begin
			m_wen = 1'b1;
			m_wdata = {m_regs[rd][15:8], ins[7:0]};
		end
		4'hB: begin
			m_wen = 1'b1;
			m_wdata = {ins[7:0], m_regs[rd][7:0]};
		end
		4'hC: begin
			if (branch_cond(ins[11:9])) begin
				next_pc = m_pc + 16'd2 + {{6{ins[8]}}, ins[8:0], 1'b0};
			end
		end
		4'hE: begin
			m_wen = 1'b1;
			m_wdata = m_pc + 16'd2;
		end
		4'hF: begin
			m_halt = 1'b1;
			next_pc = m_pc;
		end
		default: begin
			// unused opcodes only advance
		end
	endcase
	if (m_wen) begin
		m_regs[rd] = m_wdata;
	end
	m_pc = next_pc;
endtask

// one random instruction with r1 kept as the memory base
function automatic logic [`CPU_XLEN-1:0] pick_instr(input int maxoff);
	int kind;
	logic [3:0] rd;
	logic [3:0] rs;
	logic [3:0] rt;
	logic [8:0] off;
	logic [`CPU_XLEN-1:0] ins;
	kind = int'($urandom_range(0, 11));
	rd = 4'($urandom_range(2, 15));
	rs = 4'($urandom_range(0, 15));
	rt = 4'($urandom_range(0, 15));
	off = 9'($urandom_range(0, (maxoff < 3) ? maxoff : 3));
	// a load needs a word stored earlier on this path
	if (kind == 6 && stored_off.size() == 0) begin
		kind = 7;
	end
	case (kind)
		0: ins = {4'h0, rd, rs, rt};
		1: ins = {4'h1, rd, rs, rt};
		2: ins = {4'h2, rd, rs, rt};
		3: ins = {4'h4, rd, rs, rt};
		4: ins = {4'h5, rd, rs, rt};
		5: ins = {4'h6, rd, rs, rt};
		6: ins = {4'h8, rd, 4'h1,
			4'(stored_off[$urandom_range(0, stored_off.size() - 1)])};
		7: begin
			ins = {4'h9, rs, 4'h1, rt};
			stored_off.push_back(int'(rt));
		end
		8: ins = {4'hA, rd, 8'($urandom)};
		9: ins = {4'hB, rd, 8'($urandom)};
		10: ins = {4'hC, 3'($urandom_range(0, 7)), off};
		default: ins = {4'hE, rd, 8'h00};
	endcase
	return ins;
endfunction

// built along the executed path so forward branches skip filler
task automatic build_program();
	int pcw;
	logic [`CPU_XLEN-1:0] ins;
	for (int i = 0; i < PROG_WORDS; i++) begin
		prog[i] = {4'h2, 12'($urandom)};
	end
	stored_off.delete();
	reset_model();
	pcw = 0;
	while (pcw < PROG_WORDS - 1) begin
		if (pcw == 0) begin
			ins = {4'hA, 4'h1, 8'($urandom_range(16, 239))};
		end else begin
			ins = pick_instr(PROG_WORDS - 2 - pcw);
		end
		prog[pcw] = ins;
		execute_instr(ins);
		pcw = int'(m_pc[15:1]);
	end
	prog[PROG_WORDS-1] = {4'hF, 12'h000};
endtask

// File: bench/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_cpu;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 3;
	// cycles hlt and pc must hold after the HLT
	localparam int HOLD_CYCLES = 5;
	localparam int IAW = $clog2(`CPU_IMEM_DEPTH);

	logic clk;
	logic reset;
	logic load_en;
	logic [IAW-1:0] load_addr;
	logic [`CPU_XLEN-1:0] load_data;
	logic hlt;
	logic [`CPU_XLEN-1:0] pc;
	logic commit_en;
	logic [$clog2(`CPU_NREGS)-1:0] commit_reg;
	logic [`CPU_XLEN-1:0] commit_data;

	int halted_cycles;

	`include "cpu_model.svh"

	// load phase plus the reset cycles after it
	localparam int RESET_TIME = PROG_WORDS + 1 + RESET_CYCLES;
	localparam int TIMEOUT_CYCLES = 4 * PROG_WORDS + RESET_TIME;

	cpu cpu_inst (
		.clk(clk),
		.reset(reset),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.hlt(hlt),
		.pc(pc),
		.commit_en(commit_en),
		.commit_reg(commit_reg),
		.commit_data(commit_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns %s: expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		halted_cycles = 0;
		void'($urandom(32'h3407c819));
		build_program();

		// one program word per falling edge, written while in reset
		for (int i = 0; i < PROG_WORDS; i++) begin
			@(negedge clk);
			load_en = 1'b1;
			load_addr = IAW'(i);
			load_data = prog[i];
		end
		@(negedge clk);
		load_en = 1'b0;

		// reset kept a few cycles past the last word
		repeat (RESET_CYCLES) begin
			#(CLK_PERIOD / 4);
			check_value("commit_en", 32'(commit_en), 32'd0);
			check_value("pc", 32'(pc), 32'd0);
			@(negedge clk);
		end

		reset_model();
		reset = 1'b0;

		// sample a quarter period before each rising edge
		while (halted_cycles <= HOLD_CYCLES) begin
			#(CLK_PERIOD / 4);
			check_value("pc", 32'(pc), 32'(m_pc));
			execute_instr(prog[int'(m_pc[15:1])]);
			check_value("hlt", 32'(hlt), 32'(m_halt));
			check_value("commit_en", 32'(commit_en), 32'(m_wen));
			if (m_wen) begin
				check_value("commit_reg", 32'(commit_reg), 32'(m_wreg));
				check_value("commit_data", 32'(commit_data), 32'(m_wdata));
			end
			if (m_halt) begin
				halted_cycles++;
			end
			@(negedge clk);
		end

		$display("Result: PASSED");
		$finish;
	end

	// program length bounds the run, four cycles per word is ample
	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("watchdog expired, the program never halted");
		$display("Result: FAILED");
		$fatal(1, "timeout");
	end

endmodule

// File: filelist.f
+incdir+rtl
+incdir+bench
rtl/cpu_pkg.sv
rtl/cpu_if.sv
rtl/fetch_unit.sv
rtl/core_execute.sv
rtl/mem_writeback.sv
rtl/cpu.sv
bench/tb_cpu.sv

// File: Makefile
TOP := tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf obj_dir
